// File: dv/mips_cpu_bus_tb.sv
`timescale 1ns/1ps

module mips_cpu_bus_tb;
    import mips_pkg::*;

    localparam word_t RESET_VECTOR = 32'hBFC0_0000;
    localparam int    NUM_TESTS    = 5;
    localparam int    HALT_LIMIT   = 1500; // Cycles allowed per program

    logic       clk;
    logic       rst;
    logic       active;
    word_t      register_v0;
    logic       waitrequest;
    word_t      readdata;
    word_t      address;
    logic       write;
    logic       read;
    word_t      writedata;
    logic [3:0] byteenable;

    // Memory model controls
    logic        stall_en;
    logic        clear;
    logic        load_en;
    logic [10:0] load_idx;
    word_t       load_word;

    int    errors;       // Value checks and halt failures
    int    bus_errors;   // Protocol violations from the monitor
    int    failed_tests;
    int    writes_seen;
    int    reads_seen;
    int    stalls_seen;
    logic  [3:0] be_and; // AND of byteenable over all writes
    logic  prev_read;
    logic  prev_write;
    logic  prev_wait;
    word_t prog[$];      // Program image with word 0 at RESET_VECTOR

    mips_cpu_bus #(.RESET_VECTOR(RESET_VECTOR)) dut0 (
        .clk, .rst, .active, .register_v0,
        .waitrequest, .readdata, .address, .write, .read, .writedata, .byteenable
    );

    tb_memory mem0 (
        .clk, .stall_en, .clear, .load_en, .load_idx, .load_word,
        .address, .write, .writedata, .waitrequest, .readdata
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (2000 * NUM_TESTS) @(posedge clk);
        $display("Watchdog expired after %0d cycles", 2000 * NUM_TESTS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // Bus protocol monitor sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            prev_read   = 1'b0;
            prev_write  = 1'b0;
            prev_wait   = 1'b0;
            writes_seen = 0;
            reads_seen  = 0;
            stalls_seen = 0;
            be_and      = 4'hF;
        end else begin
            if (prev_wait && prev_read && !read) begin
                $display("Error at %0t: read dropped while waitrequest was high", $time);
                bus_errors++;
            end
            if (prev_wait && prev_write && !write) begin
                $display("Error at %0t: write dropped while waitrequest was high", $time);
                bus_errors++;
            end
            if (!active && (read || write)) begin
                $display("Error at %0t: bus access after active fell", $time);
                bus_errors++;
            end
            if (write) be_and = be_and & byteenable;
            if (write && !waitrequest) writes_seen++;     // Completes at next edge
            if (read && !waitrequest) reads_seen++;
            if ((read || write) && waitrequest) stalls_seen++;
            prev_read  = read;
            prev_write = write;
            prev_wait  = waitrequest;
        end
    end

    function automatic int error_total();
        return errors + bus_errors;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Instruction encoders
    function automatic word_t rtype(input logic [4:0] rs, input logic [4:0] rt,
                                    input logic [4:0] rd, input logic [4:0] shamt,
                                    input logic [5:0] fn);
        return {OPC_SPECIAL, rs, rt, rd, shamt, fn};
    endfunction

    function automatic word_t itype(input logic [5:0] opc, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    // Target given as a word index into the program
    function automatic word_t jtype(input logic [5:0] opc, input int idx);
        word_t byte_addr;
        byte_addr = RESET_VECTOR + 32'(idx * 4);
        return {opc, byte_addr[27:2]};
    endfunction

    // Offset counts from the delay slot
    function automatic logic [15:0] branch_offset(input int from, input int to);
        return 16'(to - from - 1);
    endfunction

    function automatic word_t sext16(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic word_t zext16(input logic [15:0] imm);
        return {16'h0000, imm};
    endfunction

    // jr $0 and its nop delay slot end every program
    task automatic append_halt();
        prog.push_back(rtype(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
        prog.push_back(32'h0000_0000);
    endtask

    task automatic wait_halt();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (active && cycles < HALT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (active) begin
            $display("Error at %0t: program did not halt within %0d cycles", $time, HALT_LIMIT);
            errors++;
        end
    endtask

    // Load while the core is halted or in reset and then run from reset
    task automatic run_program(input logic stall);
        @(posedge clk);
        stall_en <= stall;
        clear    <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        foreach (prog[i]) begin
            load_en   <= 1'b1;
            load_idx  <= 11'(i);
            load_word <= prog[i];
            @(posedge clk);
        end
        load_en <= 1'b0;
        rst     <= 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        wait_halt();
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        if (error_total() == errs_at_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, error_total() - errs_at_start);
            failed_tests++;
        end
    endtask

    task automatic alu_test();
        int    errs;
        word_t r8, r9, r10, r11, r12, r13, r14, r15, r16, exp_v0;
        errs = error_total();
        prog = {};
        prog.push_back(itype(OPC_LUI, 5'd0, 5'd8, 16'h1234));
        prog.push_back(itype(OPC_ORI, 5'd8, 5'd8, 16'h8765));    // Top bit set so zero fill shows
        prog.push_back(itype(OPC_ADDIU, 5'd0, 5'd9, 16'hFFF0));  // -16
        prog.push_back(rtype(5'd8, 5'd9, 5'd10, 5'd0, FN_ADDU));
        prog.push_back(rtype(5'd10, 5'd9, 5'd11, 5'd0, FN_SUBU));
        prog.push_back(rtype(5'd11, 5'd9, 5'd12, 5'd0, FN_AND));
        prog.push_back(rtype(5'd12, 5'd8, 5'd13, 5'd0, FN_XOR));
        prog.push_back(rtype(5'd9, 5'd13, 5'd14, 5'd0, FN_SLT));   // Signed compare
        prog.push_back(rtype(5'd0, 5'd8, 5'd15, 5'd4, FN_SLL));
        prog.push_back(rtype(5'd0, 5'd9, 5'd16, 5'd28, FN_SRL));
        // Fold every result into v0
        prog.push_back(rtype(5'd10, 5'd11, 5'd2, 5'd0, FN_ADDU));
        prog.push_back(rtype(5'd2, 5'd12, 5'd2, 5'd0, FN_XOR));
        prog.push_back(rtype(5'd2, 5'd13, 5'd2, 5'd0, FN_ADDU));
        prog.push_back(rtype(5'd2, 5'd14, 5'd2, 5'd0, FN_ADDU));
        prog.push_back(rtype(5'd2, 5'd15, 5'd2, 5'd0, FN_XOR));
        prog.push_back(rtype(5'd2, 5'd16, 5'd2, 5'd0, FN_ADDU));
        append_halt();
        // Reference values from the MIPS extension rules
        r8  = {16'h1234, 16'h0000};
        r8  = r8 | zext16(16'h8765);
        r9  = sext16(16'hFFF0);
        r10 = r8 + r9;
        r11 = r10 - r9;
        r12 = r11 & r9;
        r13 = r12 ^ r8;
        r14 = ($signed(r9) < $signed(r13)) ? 32'd1 : 32'd0;
        r15 = r8 << 4;
        r16 = r9 >> 28;
        exp_v0 = (((((r10 + r11) ^ r12) + r13) + r14) ^ r15) + r16;
        run_program(1'b0);
        check_value("register_v0", register_v0, exp_v0);
        report_test("1 alu arithmetic and logic", errs);
    endtask

    task automatic load_store_test();
        int    errs;
        word_t base, r9, r10, addr_hi, addr_lo;
        errs = error_total();
        prog = {};
        prog.push_back(itype(OPC_ADDIU, 5'd0, 5'd8, 16'h0400)); // Data area base
        prog.push_back(itype(OPC_LUI, 5'd0, 5'd9, 16'hCAFE));
        prog.push_back(itype(OPC_ORI, 5'd9, 5'd9, 16'h1234));
        prog.push_back(rtype(5'd9, 5'd9, 5'd10, 5'd0, FN_ADDU));
        prog.push_back(itype(OPC_SW, 5'd8, 5'd10, 16'h0008));
        prog.push_back(itype(OPC_SW, 5'd8, 5'd9, 16'hFFFC));    // Negative offset
        prog.push_back(itype(OPC_LW, 5'd8, 5'd2, 16'h0008));
        prog.push_back(itype(OPC_LW, 5'd8, 5'd11, 16'hFFFC));
        prog.push_back(rtype(5'd2, 5'd11, 5'd2, 5'd0, FN_XOR));
        append_halt();
        base    = sext16(16'h0400);
        r9      = {16'hCAFE, 16'h0000} | zext16(16'h1234);
        r10     = r9 + r9;
        addr_hi = base + sext16(16'h0008);
        addr_lo = base + sext16(16'hFFFC);
        run_program(1'b0);
        check_value("register_v0", register_v0, r10 ^ r9);
        check_value("mem at base+8", mem0.mem[addr_hi[12:2]], r10);
        check_value("mem at base-4", mem0.mem[addr_lo[12:2]], r9);
        check_value("writes completed", writes_seen, 32'd2);
        // One fetch per straight-line instruction plus the two loads
        check_value("reads completed", reads_seen, 32'(prog.size() + 2));
        check_value("byteenable", {28'b0, be_and}, 32'h0000_000F);
        report_test("2 load and store", errs);
    endtask

    // Delay slots add 1, 2, 8 and 16 and the not-taken path adds 4
    task automatic build_branch_program();
        prog = {};
        prog.push_back(itype(OPC_ADDIU, 5'd0, 5'd2, 16'h0000));
        prog.push_back(itype(OPC_ADDIU, 5'd0, 5'd8, 16'h0005));
        prog.push_back(itype(OPC_ADDIU, 5'd0, 5'd9, 16'h0005));
        prog.push_back(itype(OPC_BEQ, 5'd8, 5'd9, branch_offset(3, 7)));  // Taken
        prog.push_back(itype(OPC_ADDIU, 5'd2, 5'd2, 16'h0001));
        prog.push_back(itype(OPC_ADDIU, 5'd2, 5'd2, 16'h0100));          // Skipped
        prog.push_back(itype(OPC_ADDIU, 5'd2, 5'd2, 16'h0100));          // Skipped
        prog.push_back(itype(OPC_BNE, 5'd8, 5'd9, branch_offset(7, 10))); // Not taken
        prog.push_back(itype(OPC_ADDIU, 5'd2, 5'd2, 16'h0002));
        prog.push_back(itype(OPC_ADDIU, 5'd2, 5'd2, 16'h0004));          // Fall-through
        prog.push_back(jtype(OPC_J, 13));
        prog.push_back(itype(OPC_ADDIU, 5'd2, 5'd2, 16'h0008));
        prog.push_back(itype(OPC_ADDIU, 5'd2, 5'd2, 16'h0100));          // Skipped
        prog.push_back(rtype(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
        prog.push_back(itype(OPC_ADDIU, 5'd2, 5'd2, 16'h0010));          // Slot of jr $0
    endtask

    function automatic word_t branch_result();
        return 32'd1 + 32'd2 + 32'd4 + 32'd8 + 32'd16;
    endfunction

    task automatic branch_test();
        int errs;
        errs = error_total();
        build_branch_program();
        run_program(1'b0);
        check_value("register_v0", register_v0, branch_result());
        report_test("3 branches with delay slot", errs);
    endtask

    task automatic link_halt_test();
        int errs;
        int high_cycles;
        errs        = error_total();
        high_cycles = 0;
        prog = {};
        prog.push_back(jtype(OPC_JAL, 4));
        prog.push_back(itype(OPC_ADDIU, 5'd0, 5'd3, 16'h0001));  // Delay slot
        prog.push_back(itype(OPC_ADDIU, 5'd0, 5'd2, 16'h0BAD));  // Return point is skipped
        prog.push_back(itype(OPC_ADDIU, 5'd0, 5'd2, 16'h0BAD));
        prog.push_back(rtype(5'd31, 5'd3, 5'd2, 5'd0, FN_ADDU));
        append_halt();
        run_program(1'b0);
        check_value("register_v0", register_v0, RESET_VECTOR + 32'd8 + 32'd1);
        repeat (20) begin
            @(negedge clk);
            if (active) high_cycles++;
        end
        if (high_cycles != 0) begin
            $display("Error at %0t: active rose again after halt", $time);
            errors++;
        end
        report_test("4 link and halt", errs);
    endtask

    task automatic stall_test();
        int errs;
        errs = error_total();
        build_branch_program();
        run_program(1'b1);
        check_value("register_v0", register_v0, branch_result());
        if (stalls_seen == 0) begin
            $display("Error at %0t: no waitrequest stall was seen on the bus", $time);
            errors++;
        end
        report_test("5 random stalls", errs);
    endtask

    initial begin
        rst          = 1'b1;  // Held from time zero until the first run
        stall_en     = 1'b0;
        clear        = 1'b0;
        load_en      = 1'b0;
        load_idx     = '0;
        load_word    = '0;
        errors       = 0;
        bus_errors   = 0;
        failed_tests = 0;
        alu_test();
        load_store_test();
        branch_test();
        link_halt_test();
        stall_test();
        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 NUM_TESTS, failed_tests, error_total());
        if (error_total() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: dv/tb_memory.sv
`timescale 1ns/1ps

module tb_memory (
    input  logic            clk,
    input  logic            stall_en,   // Random waitrequest when high
    input  logic            clear,      // Fills the whole array with its pattern
    input  logic            load_en,
    input  logic [10:0]     load_idx,
    input  mips_pkg::word_t load_word,
    input  mips_pkg::word_t address,
    input  logic            write,
    input  mips_pkg::word_t writedata,
    output logic            waitrequest,
    output mips_pkg::word_t readdata
);
    import mips_pkg::*;

    localparam logic [15:0] SEED = 16'd25982;

    word_t       mem [2048];
    logic [15:0] lfsr;
    logic [10:0] idx;

    // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    assign idx      = address[12:2]; // RESET_VECTOR and 0 alias onto the same words
    assign readdata = mem[idx];      // Valid on the edge that ends the transfer

    initial begin
        lfsr        = SEED;
        waitrequest = 1'b0;
    end

    always @(posedge clk) begin
        lfsr        <= lfsr_step(lfsr);   // One step for the one bit used
        waitrequest <= stall_en && lfsr[0];
        if (clear) begin
            for (int i = 0; i < 2048; i++) begin
                // Unused opcode 0x3C, runs as a no-op if ever fetched
                mem[i] <= 32'hF00D_0000 ^ {19'b0, 11'(i), 2'b00};
            end
        end else if (load_en) begin
            mem[load_idx] <= load_word;
        end else if (write && !waitrequest) begin
            mem[idx] <= writedata;
        end
    end

endmodule

// File: flist.f
src/mips_pkg.sv
src/mips_decode.sv
src/mips_alu.sv
src/mips_regfile.sv
src/mips_sequencer.sv
src/mips_cpu_bus.sv
dv/tb_memory.sv
dv/mips_cpu_bus_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module mips_cpu_bus_tb -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vmips_cpu_bus_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

// File: src/mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::op_t   op,
    input  mips_pkg::word_t rs_data,
    input  mips_pkg::word_t rt_data,
    input  mips_pkg::imm_t  imm,
    input  logic [4:0]      shamt,
    output mips_pkg::word_t alu_result,
    output logic            branch_taken
);
    import mips_pkg::*;

    word_t imm_sext; // Arithmetic and address offsets
    word_t imm_zext; // Logic immediates

    assign imm_sext = {{16{imm[15]}}, imm};
    assign imm_zext = {16'b0, imm};

    always_comb begin
        case (op)
            // Effective address shares the adder with addiu
            OP_ADDIU, OP_LW, OP_SW:
                alu_result = rs_data + imm_sext;
            OP_ADDU: alu_result = rs_data + rt_data;
            OP_SUBU: alu_result = rs_data - rt_data;
            OP_AND:  alu_result = rs_data & rt_data;
            OP_ANDI: alu_result = rs_data & imm_zext;
            OP_OR:   alu_result = rs_data | rt_data;
            OP_ORI:  alu_result = rs_data | imm_zext;
            OP_XOR:  alu_result = rs_data ^ rt_data;
            OP_XORI: alu_result = rs_data ^ imm_zext;
            OP_SLT: begin
                alu_result = {31'b0, $signed(rs_data) < $signed(rt_data)};
            end
            OP_SLTU: alu_result = {31'b0, rs_data < rt_data};
            OP_LUI:  alu_result = {imm, 16'b0};    // Upper half load
            OP_SLL:  alu_result = rt_data << shamt;
            OP_SRL:  alu_result = rt_data >> shamt; // Logical, zero fill
            default: alu_result = '0;
        endcase
    end

    // Equality compare for the two branches
    always_comb begin
        case (op)
            OP_BEQ:  branch_taken = (rs_data == rt_data);
            OP_BNE:  branch_taken = (rs_data != rt_data);
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// File: src/mips_cpu_bus.sv
`timescale 1ns/1ps

module mips_cpu_bus #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC0_0000
) (
    input  logic            clk,
    input  logic            rst,
    output logic            active,
    output mips_pkg::word_t register_v0,

    input  logic            waitrequest,
    input  mips_pkg::word_t readdata,
    output mips_pkg::word_t address,
    output logic            write,
    output logic            read,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable
);
    import mips_pkg::*;

    // Decoded fields
    word_t      instr;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] shamt;
    imm_t       imm;
    logic [25:0] target;
    op_t        op;
    wb_src_t    wb_src;

    // Datapath
    word_t      rs_data;
    word_t      rt_data;
    word_t      alu_result;
    logic       branch_taken;
    word_t      load_data;
    word_t      link_addr;
    cpu_state_t state;
    logic       mem_done;

    mips_decode u_decode (
        .instr, .rs, .rt, .rd, .shamt, .imm, .target, .op, .wb_src
    );

    mips_alu u_alu (
        .op, .rs_data, .rt_data, .imm, .shamt, .alu_result, .branch_taken
    );

    mips_regfile u_regfile (
        .clk, .rst, .state, .op, .wb_src, .rs, .rt, .rd,
        .alu_result, .load_data, .link_addr, .mem_done,
        .rs_data, .rt_data,
        .v0(register_v0)
    );

    mips_sequencer #(.RESET_VECTOR(RESET_VECTOR)) u_sequencer (
        .clk, .rst, .op, .target, .rs_data, .rt_data, .alu_result, .imm,
        .branch_taken, .waitrequest, .readdata,
        .instr, .load_data, .link_addr, .state, .mem_done, .active,
        .address, .writedata, .read, .write, .byteenable
    );

endmodule

// File: src/mips_decode.sv
`timescale 1ns/1ps

module mips_decode (
    input  mips_pkg::word_t     instr,
    output mips_pkg::reg_addr_t rs,
    output mips_pkg::reg_addr_t rt,
    output mips_pkg::reg_addr_t rd,
    output logic [4:0]          shamt,
    output mips_pkg::imm_t      imm,
    output logic [25:0]         target,
    output mips_pkg::op_t       op,
    output mips_pkg::wb_src_t   wb_src
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    // Fixed MIPS field positions
    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign imm    = instr[15:0];
    assign target = instr[25:0]; // J-type word index

    always_comb begin
        op = OP_ILLEGAL;
        case (opcode)
            OPC_SPECIAL: begin
                case (funct)
                    FN_SLL:  op = OP_SLL; // Also the canonical nop
                    FN_SRL:  op = OP_SRL;
                    FN_JR:   op = OP_JR;
                    FN_ADDU: op = OP_ADDU;
                    FN_SUBU: op = OP_SUBU;
                    FN_AND:  op = OP_AND;
                    FN_OR:   op = OP_OR;
                    FN_XOR:  op = OP_XOR;
                    FN_SLT:  op = OP_SLT;
                    FN_SLTU: op = OP_SLTU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            OPC_J:     op = OP_J;
            OPC_JAL:   op = OP_JAL;
            OPC_BEQ:   op = OP_BEQ;
            OPC_BNE:   op = OP_BNE;
            OPC_ADDIU: op = OP_ADDIU;
            OPC_ANDI:  op = OP_ANDI;
            OPC_ORI:   op = OP_ORI;
            OPC_XORI:  op = OP_XORI;
            OPC_LUI:   op = OP_LUI;
            OPC_LW:    op = OP_LW;
            OPC_SW:    op = OP_SW;
            default:   op = OP_ILLEGAL; // Outside the subset
        endcase
    end

    // Write-back source per operation
    always_comb begin
        case (op)
            OP_LW:   wb_src = WB_LOAD;
            OP_JAL:  wb_src = WB_LINK;
            OP_SW, OP_BEQ, OP_BNE, OP_J, OP_JR, OP_ILLEGAL:
                wb_src = WB_NONE;   // Nothing to retire into the regfile
            default: wb_src = WB_ALU;
        endcase
    end

endmodule

// File: src/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;     // Data and address word
    typedef logic [4:0]  reg_addr_t; // Register index
    typedef logic [15:0] imm_t;      // I-type immediate field

    // Multicycle sequencer states
    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM,
        HALT
    } cpu_state_t;

    // One value per supported instruction
    typedef enum logic [4:0] {
        OP_ADDIU, OP_ADDU, OP_SUBU,
        OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI,
        OP_SLT, OP_SLTU, OP_LUI, OP_SLL, OP_SRL,
        OP_LW, OP_SW,
        OP_BEQ, OP_BNE, OP_J, OP_JAL, OP_JR,
        OP_ILLEGAL                      // Runs as a no-op
    } op_t;

    typedef enum logic [1:0] {
        WB_NONE,                        // No register write
        WB_ALU,
        WB_LOAD,
        WB_LINK                         // Return address for jal
    } wb_src_t;

    // Primary opcodes
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_JAL     = 6'h03;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ANDI    = 6'h0C;
    localparam logic [5:0] OPC_ORI     = 6'h0D;
    localparam logic [5:0] OPC_XORI    = 6'h0E;
    localparam logic [5:0] OPC_LUI     = 6'h0F;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2B;

    // SPECIAL function field
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2A;
    localparam logic [5:0] FN_SLTU = 6'h2B;

endpackage

// File: src/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::cpu_state_t state,
    input  mips_pkg::op_t       op,
    input  mips_pkg::wb_src_t   wb_src,
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    input  mips_pkg::reg_addr_t rd,
    input  mips_pkg::word_t     alu_result,
    input  mips_pkg::word_t     load_data,
    input  mips_pkg::word_t     link_addr,
    input  logic                mem_done,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    output mips_pkg::word_t     v0
);
    import mips_pkg::*;

    word_t     regs [32];
    reg_addr_t waddr;
    word_t     wdata;
    logic      we;

    // Destination is rd for R-type, ra for jal, rt otherwise
    always_comb begin
        case (op)
            OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU, OP_SLL, OP_SRL:
                waddr = rd;
            OP_JAL:  waddr = 5'd31;
            default: waddr = rt;
        endcase
    end

    always_comb begin
        case (wb_src)
            WB_LOAD: wdata = load_data;
            WB_LINK: wdata = link_addr;
            default: wdata = alu_result;
        endcase
    end

    // ALU and link at end of EXEC, load at the completing MEM edge
    assign we = (state == EXEC && (wb_src == WB_ALU || wb_src == WB_LINK))
             || (mem_done && wb_src == WB_LOAD);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin // $zero stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rs_data = regs[rs];
    assign rt_data = regs[rt];
    assign v0      = regs[2]; // Harness result register

    // Sequencer state must gate every write
    a_write_window: assert property (@(posedge clk) disable iff (rst)
        we |-> (state == EXEC || state == MEM));

endmodule

// File: src/mips_sequencer.sv
`timescale 1ns/1ps

module mips_sequencer #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC0_0000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  mips_pkg::op_t        op,
    input  logic [25:0]          target,
    input  mips_pkg::word_t      rs_data,
    input  mips_pkg::word_t      rt_data,
    input  mips_pkg::word_t      alu_result,
    input  mips_pkg::imm_t       imm,
    input  logic                 branch_taken,
    input  logic                 waitrequest,
    input  mips_pkg::word_t      readdata,
    output mips_pkg::word_t      instr,
    output mips_pkg::word_t      load_data,
    output mips_pkg::word_t      link_addr,
    output mips_pkg::cpu_state_t state,
    output logic                 mem_done,
    output logic                 active,
    output mips_pkg::word_t      address,
    output mips_pkg::word_t      writedata,
    output logic                 read,
    output logic                 write,
    output logic [3:0]           byteenable
);
    import mips_pkg::*;

    word_t pc;         // Address of the instruction in flight
    word_t next_pc;    // Following fetch that carries the target across a delay slot
    word_t pc_plus4;
    word_t branch_tgt;
    word_t jump_tgt;
    word_t redirect_tgt;
    logic  redirect;

    assign pc_plus4   = pc + 32'd4;
    assign branch_tgt = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
    assign jump_tgt   = {pc_plus4[31:28], target, 2'b00}; // Stays in the 256 MB region
    assign link_addr  = pc + 32'd8;                        // Skips the delay slot

    always_comb begin
        redirect     = 1'b0;
        redirect_tgt = jump_tgt;
        case (op)
            OP_J, OP_JAL: redirect = 1'b1;
            OP_JR: begin
                redirect     = 1'b1;
                redirect_tgt = rs_data;
            end
            OP_BEQ, OP_BNE: begin
                redirect     = branch_taken;
                redirect_tgt = branch_tgt;
            end
            default: redirect = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= FETCH;
            pc      <= RESET_VECTOR;
            next_pc <= RESET_VECTOR + 32'd4;
        end else begin
            case (state)
                FETCH: if (!waitrequest) state <= EXEC;
                EXEC: begin
                    pc      <= next_pc; // Delay slot or fall-through
                    next_pc <= redirect ? redirect_tgt : next_pc + 32'd4;
                    if (op == OP_LW || op == OP_SW) state <= MEM;
                    else if (next_pc == '0)         state <= HALT;
                    else                            state <= FETCH;
                end
                MEM: if (!waitrequest) state <= (pc == '0) ? HALT : FETCH;
                default: state <= HALT; // Parked until reset
            endcase
        end
    end

    // Instruction register loaded by each completed fetch
    always_ff @(posedge clk) begin
        if (state == FETCH && !waitrequest) instr <= readdata;
    end

    assign mem_done   = (state == MEM) && !waitrequest;
    assign load_data  = readdata;  // Sampled by the regfile at the mem_done edge
    assign active     = (state != HALT);
    assign read       = (state == FETCH) || (state == MEM && op == OP_LW);
    assign write      = (state == MEM && op == OP_SW);
    assign address    = (state == FETCH) ? pc : alu_result;
    assign writedata  = rt_data;
    assign byteenable = 4'b1111;   // Word accesses only

    a_read_held: assert property (@(posedge clk) disable iff (rst)
        read && waitrequest |=> read && $stable(address));
    a_write_held: assert property (@(posedge clk) disable iff (rst)
        write && waitrequest |=> write && $stable(address) && $stable(writedata));

endmodule
